// ==== ldpc_enc_top.f ====
+incdir+logic
logic/ldpc_enc_pkg.sv
logic/ldpc_enc_mem_if.sv
logic/ldpc_enc_info_ram.sv
logic/ldpc_enc_loader.sv
logic/ldpc_enc_addr_gen.sv
logic/ldpc_enc_acu.sv
logic/ldpc_enc_top.sv
tb/ldpc_enc_asserts.sv
tb/ldpc_enc_tb.sv

// ==== logic/ldpc_enc_acu.sv ====
// LDPC encoder accumulation unit
// bit-aligns each read window and XORs it into the parity words,
// then streams row 0 and row 1 parity out

`timescale 1ns/1ns

`include "ldpc_enc_defs.svh"

module ldpc_enc_acu import ldpc_enc_pkg::*; (
  input  logic      iclk,
  input  logic      rst_n,
  input  logic      start,
  input  logic      step_valid,
  input  logic      step_first,
  input  logic      row_ena   [`LDPC_NC],
  input  word_idx_t row_word  [`LDPC_NC],
  input  shift_t    row_shift [`LDPC_NC],
  input  logic      frame_done,
  input  dat_t      rdata,
  output logic      out_valid,
  output dat_t      out_word,
  output logic      out_last,
  output logic      busy
);

  localparam int               WI_W     = $bits(word_idx_t);
  localparam int               OUT_W    = $clog2(`LDPC_NC) + WI_W;
  localparam logic [OUT_W-1:0] OUT_LAST = OUT_W'(`LDPC_NC * `LDPC_BASE - 1);

  dat_t                      par [`LDPC_NC][`LDPC_BASE];  // parity accumulators
  dat_t                      prev_word;
  dat_t                      aligned [`LDPC_NC];
  logic [2*`LDPC_DAT_W-1:0]  win;                         // current over previous
  logic [OUT_W-1:0]          out_cnt;                     // row, word
  logic                      acc_go;

  // ------------------------------------------------------------
  // alignment
  // ------------------------------------------------------------

  assign win    = {rdata, prev_word};
  assign acc_go = step_valid & ~step_first;

  always_comb begin
    for (int c = 0; c < `LDPC_NC; c++) begin
      aligned[c] = dat_t'(win >> row_shift[c]);  // 4 bits from shift up
    end
  end

  always_ff @(posedge iclk) begin
    if (step_valid) begin
      prev_word <= rdata;
    end
  end

  // ------------------------------------------------------------
  // accumulate
  // ------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (start) begin
      for (int c = 0; c < `LDPC_NC; c++) begin
        for (int w = 0; w < `LDPC_BASE; w++) begin
          par[c][w] <= '0;
        end
      end
    end else if (acc_go) begin
      for (int c = 0; c < `LDPC_NC; c++) begin
        if (row_ena[c]) begin
          par[c][row_word[c]] <= par[c][row_word[c]] ^ aligned[c];
        end
      end
    end
  end

  // ------------------------------------------------------------
  // output stream
  // ------------------------------------------------------------

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      out_valid <= 1'b0;
      out_cnt   <= '0;
    end else begin
      if (start) begin
        busy <= 1'b1;
      end else if (out_last) begin
        busy <= 1'b0;  // drops right after the 8th word
      end
      if (step_valid & frame_done) begin
        out_valid <= 1'b1;  // parity complete after this step
        out_cnt   <= '0;
      end else if (out_valid) begin
        out_cnt <= out_cnt + 1'b1;
        if (out_cnt == OUT_LAST) begin
          out_valid <= 1'b0;
        end
      end
    end
  end

  assign out_last = out_valid & (out_cnt == OUT_LAST);
  assign out_word = par[out_cnt[OUT_W-1:WI_W]][out_cnt[WI_W-1:0]];

endmodule

// ==== logic/ldpc_enc_addr_gen.sv ====
// LDPC encoder address generator
// walks Hb columns with 5 reads each (words 0..3, then 0 again)
// and issues per-row target word and bit shift aligned to rdata

`timescale 1ns/1ns

`include "ldpc_enc_defs.svh"

module ldpc_enc_addr_gen import ldpc_enc_pkg::*; (
  input  logic              iclk,
  input  logic              rst_n,
  input  logic              start,
  input  logic              rd_bank,
  input  logic              frame_ready,
  input  logic              busy,
  output logic              start_acc,   // accepted start, to the ACU
  ldpc_enc_mem_if.requester mem,
  output logic              step_valid,
  output logic              step_first,
  output logic              row_ena   [`LDPC_NC],
  output word_idx_t         row_word  [`LDPC_NC],
  output shift_t            row_shift [`LDPC_NC],
  output logic              frame_done
);

  localparam int       CNT_W    = $clog2(`LDPC_BASE + 1);
  localparam int       RD_LAST  = `LDPC_BASE;  // wrap read index
  localparam col_idx_t COL_LAST = col_idx_t'(`LDPC_NT - 1);

  logic             running;
  logic             bank;         // bank under encode
  logic             frame_avail;  // a stored frame not yet encoded
  col_idx_t         col;
  logic [CNT_W-1:0] rd_cnt;       // 0..4 inside a column
  word_idx_t        rd_word;
  word_idx_t        win_lo;       // word at the window's low half
  logic             rd_wrap;
  logic             col_last;
  logic             step;

  // ------------------------------------------------------------
  // start and frame bookkeeping
  // ------------------------------------------------------------

  assign start_acc = start & ~busy & ~running & (frame_avail | frame_ready);

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      frame_avail <= 1'b0;
    end else if (start_acc) begin
      frame_avail <= frame_avail & frame_ready;  // one consumed
    end else begin
      frame_avail <= frame_avail | frame_ready;
    end
  end

  // ------------------------------------------------------------
  // read sequence
  // ------------------------------------------------------------

  assign rd_word  = word_idx_t'(rd_cnt);          // index 4 maps to word 0
  assign win_lo   = word_idx_t'(rd_cnt - 1'b1);   // previous word
  assign rd_wrap  = (rd_cnt == CNT_W'(RD_LAST));
  assign col_last = (col == COL_LAST);
  assign step     = mem.gnt;                      // advance only on grant

  assign mem.req   = running;
  assign mem.we    = 1'b0;  // read only
  assign mem.addr  = {bank, col, rd_word};
  assign mem.wdata = '0;

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      running    <= 1'b0;
      bank       <= 1'b0;
      col        <= '0;
      rd_cnt     <= '0;
      step_valid <= 1'b0;
      step_first <= 1'b0;
      frame_done <= 1'b0;
      for (int c = 0; c < `LDPC_NC; c++) begin
        row_ena[c] <= 1'b0;
      end
    end else begin
      if (start_acc) begin
        running <= 1'b1;
        bank    <= rd_bank;
        col     <= '0;
        rd_cnt  <= '0;
      end else if (step) begin
        rd_cnt <= rd_wrap ? '0 : rd_cnt + 1'b1;
        if (rd_wrap) begin
          col <= col + 1'b1;
          if (col_last) begin
            running <= 1'b0;  // last read of the frame
          end
        end
      end
      // control delayed by one, lines up with rdata
      step_valid <= step;
      step_first <= step & (rd_cnt == '0);
      frame_done <= step & rd_wrap & col_last;
      for (int c = 0; c < `LDPC_NC; c++) begin
        // first read only primes the window
        row_ena[c] <= step & (rd_cnt != '0) & ~hb_tab[c][col].fld.empty;
      end
    end
  end

  // per-row target word rotates with the window
  always_ff @(posedge iclk) begin
    if (step) begin
      for (int c = 0; c < `LDPC_NC; c++) begin
        row_word[c]  <= win_lo - hb_tab[c][col].fld.woff;  // mod 4
        row_shift[c] <= hb_tab[c][col].fld.bshift;
      end
    end
  end

endmodule

// ==== logic/ldpc_enc_defs.svh ====
// LDPC encoder parity accumulator
// code dimensions and word size shared by package and RTL

`ifndef LDPC_ENC_DEFS_SVH
`define LDPC_ENC_DEFS_SVH

// ------------------------------------------------------------
// circulant geometry
// ------------------------------------------------------------

`define LDPC_ZF     16                          // circulant (block) size in bits
`define LDPC_DAT_W  4                           // bits per RAM / stream word
`define LDPC_BASE   (`LDPC_ZF / `LDPC_DAT_W)    // words per block

// ------------------------------------------------------------
// base matrix size
// ------------------------------------------------------------

`define LDPC_NC     2   // check rows of Hb
`define LDPC_NT     4   // information columns of Hb

`endif

// ==== logic/ldpc_enc_info_ram.sv ====
// two-frame info word RAM shared by loader and engine
// single access per cycle, loader port always wins

`timescale 1ns/1ns

module ldpc_enc_info_ram import ldpc_enc_pkg::*; (
  input logic             iclk,
  input logic             rst_n,
  ldpc_enc_mem_if.arbiter ld_port,
  ldpc_enc_mem_if.arbiter eng_port
);

  localparam int DEPTH = 2 ** $bits(ram_addr_t);  // both banks

  dat_t      mem [DEPTH];
  logic      ld_gnt;
  logic      eng_gnt;
  logic      acc_we;
  logic      acc_re;
  ram_addr_t acc_addr;
  dat_t      acc_wdata;
  dat_t      rd_q;

  // ------------------------------------------------------------
  // fixed priority grant
  // ------------------------------------------------------------

  // input stream has no back-pressure, so the loader never waits
  assign ld_gnt  = ld_port.req;
  assign eng_gnt = eng_port.req & ~ld_port.req;  // engine fills idle slots

  assign ld_port.gnt  = ld_gnt;
  assign eng_port.gnt = eng_gnt;

  // granted port owns the array this cycle
  always_comb begin
    if (ld_gnt) begin
      acc_addr  = ld_port.addr;
      acc_wdata = ld_port.wdata;
      acc_we    = ld_port.we;
    end else begin
      acc_addr  = eng_port.addr;
      acc_wdata = eng_port.wdata;
      acc_we    = eng_gnt & eng_port.we;
    end
  end

  assign acc_re = (ld_gnt & ~ld_port.we) | (eng_gnt & ~eng_port.we);

  // ------------------------------------------------------------
  // storage
  // ------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (acc_we) begin
      mem[acc_addr] <= acc_wdata;
    end
  end

  // read register, holds between reads
  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      rd_q <= '0;
    end else if (acc_re) begin
      rd_q <= mem[acc_addr];
    end
  end

  assign ld_port.rdata  = rd_q;
  assign eng_port.rdata = rd_q;

endmodule

// ==== logic/ldpc_enc_loader.sv ====
// frame loader
// writes incoming words into the fill bank, flips banks every 16 words

`timescale 1ns/1ns

module ldpc_enc_loader import ldpc_enc_pkg::*; (
  input  logic              iclk,
  input  logic              rst_n,
  input  logic              in_valid,
  input  dat_t              in_word,
  ldpc_enc_mem_if.requester mem,
  output logic              frame_ready,
  output logic              rd_bank
);

  localparam col_idx_t  COL_LAST  = col_idx_t'(`LDPC_NT - 1);
  localparam word_idx_t WORD_LAST = word_idx_t'(`LDPC_BASE - 1);

  logic      wr_bank;  // bank being filled
  col_idx_t  wr_col;
  word_idx_t wr_word;
  logic      frame_end;

  // write straight through, no buffering
  assign mem.req   = in_valid;
  assign mem.we    = 1'b1;
  assign mem.addr  = {wr_bank, wr_col, wr_word};
  assign mem.wdata = in_word;

  assign frame_end = (wr_col == COL_LAST) && (wr_word == WORD_LAST);

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_bank     <= 1'b0;
      wr_col      <= '0;
      wr_word     <= '0;
      rd_bank     <= 1'b0;
      frame_ready <= 1'b0;
    end else begin
      frame_ready <= 1'b0;  // single cycle pulse
      if (mem.gnt) begin
        wr_word <= wr_word + 1'b1;
        if (wr_word == WORD_LAST) begin
          wr_col <= wr_col + 1'b1;  // wraps at frame end
        end
        if (frame_end) begin
          wr_bank     <= ~wr_bank;
          rd_bank     <= wr_bank;   // finished bank goes to the engine
          frame_ready <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== logic/ldpc_enc_mem_if.sv ====
// info RAM requester port
// request held until granted, read data one cycle after grant

`timescale 1ns/1ns

interface ldpc_enc_mem_if import ldpc_enc_pkg::*; ();

  logic      req;    // access wanted
  logic      we;     // write when set
  ram_addr_t addr;
  dat_t      wdata;
  logic      gnt;    // access happens this cycle
  dat_t      rdata;  // valid the cycle after a read grant

  modport requester (
    output req,
    output we,
    output addr,
    output wdata,
    input  gnt,
    input  rdata
  );

  modport arbiter (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output gnt,
    output rdata
  );

endinterface

// ==== logic/ldpc_enc_pkg.sv ====
// LDPC encoder types and the fixed base matrix
// Hb entries decode both as signed shift and as word/bit fields

`include "ldpc_enc_defs.svh"

package ldpc_enc_pkg;

  typedef logic [`LDPC_DAT_W-1:0]           dat_t;       // one data word
  typedef logic [$clog2(`LDPC_BASE)-1:0]    word_idx_t;  // word inside a block
  typedef logic [$clog2(`LDPC_NT)-1:0]      col_idx_t;   // Hb column
  typedef logic [$clog2(`LDPC_DAT_W)-1:0]   shift_t;     // bit shift inside a word

  // bank, column, word
  typedef logic [$clog2(`LDPC_NT)+$clog2(`LDPC_BASE):0] ram_addr_t;

  // ------------------------------------------------------------
  // Hb entry, 8 bits
  // ------------------------------------------------------------

  typedef struct packed {
    logic       empty;   // set for -1
    logic [2:0] rsvd;
    word_idx_t  woff;    // shift / word width
    shift_t     bshift;  // shift mod word width
  } hb_fields_t;

  typedef union packed {
    logic signed [7:0] raw;  // circulant shift, -1 empty
    hb_fields_t        fld;
  } hb_entry_u;

  // the code, row 0 = (5, -1, 9, 14), row 1 = (0, 7, -1, 3)
  localparam hb_entry_u hb_tab [`LDPC_NC][`LDPC_NT] = '{
    '{8'h05, 8'hff, 8'h09, 8'h0e},
    '{8'h00, 8'h07, 8'hff, 8'h03}
  };

endpackage

// ==== logic/ldpc_enc_top.sv ====
// LDPC encoder parity accumulator, top level
// loader and address generator share the info RAM, ACU streams parity

`timescale 1ns/1ns

`include "ldpc_enc_defs.svh"

module ldpc_enc_top import ldpc_enc_pkg::*; (
  input  logic iclk,
  input  logic rst_n,
  input  logic in_valid,
  input  dat_t in_word,
  input  logic start,
  output logic out_valid,
  output dat_t out_word,
  output logic out_last,
  output logic busy
);

  logic      frame_ready;
  logic      rd_bank;
  logic      start_acc;
  logic      step_valid;
  logic      step_first;
  logic      row_ena   [`LDPC_NC];
  word_idx_t row_word  [`LDPC_NC];
  shift_t    row_shift [`LDPC_NC];
  logic      frame_done;

  ldpc_enc_mem_if ld_if ();   // loader side
  ldpc_enc_mem_if eng_if ();  // engine side

  ldpc_enc_info_ram u_ram (
    .iclk     (iclk),
    .rst_n    (rst_n),
    .ld_port  (ld_if.arbiter),
    .eng_port (eng_if.arbiter)
  );

  ldpc_enc_loader u_loader (
    .iclk        (iclk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_word     (in_word),
    .mem         (ld_if.requester),
    .frame_ready (frame_ready),
    .rd_bank     (rd_bank)
  );

  ldpc_enc_addr_gen u_addr_gen (
    .iclk        (iclk),
    .rst_n       (rst_n),
    .start       (start),
    .rd_bank     (rd_bank),
    .frame_ready (frame_ready),
    .busy        (busy),
    .start_acc   (start_acc),
    .mem         (eng_if.requester),
    .step_valid  (step_valid),
    .step_first  (step_first),
    .row_ena     (row_ena),
    .row_word    (row_word),
    .row_shift   (row_shift),
    .frame_done  (frame_done)
  );

  ldpc_enc_acu u_acu (
    .iclk       (iclk),
    .rst_n      (rst_n),
    .start      (start_acc),
    .step_valid (step_valid),
    .step_first (step_first),
    .row_ena    (row_ena),
    .row_word   (row_word),
    .row_shift  (row_shift),
    .frame_done (frame_done),
    .rdata      (eng_if.rdata),
    .out_valid  (out_valid),
    .out_word   (out_word),
    .out_last   (out_last),
    .busy       (busy)
  );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the LDPC encoder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module ldpc_enc_tb -Mdir obj_dir -o sim_ldpc_enc \
  -f ldpc_enc_top.f

sim_out=$(./obj_dir/sim_ldpc_enc 2>&1) || true
echo "$sim_out"

if grep -q "TESTS PASSED" <<< "$sim_out"; then
  exit 0
fi
exit 1

// ==== tb/ldpc_enc_asserts.sv ====
// LDPC encoder assertion checker
// info RAM arbitration and parity output framing, attached by bind

`timescale 1ns/1ns

module ldpc_enc_asserts (
  input logic iclk,
  input logic rst_n,
  input logic ld_req,
  input logic ld_gnt,
  input logic eng_gnt,
  input logic out_valid,
  input logic out_last,
  input logic busy
);

  // ------------------------------------------------------------
  // shared RAM arbitration
  // ------------------------------------------------------------

  gnt_exclusive: assert property (@(posedge iclk) disable iff (!rst_n)
    !(ld_gnt && eng_gnt))
    else $error("loader and engine granted in the same cycle");

  ld_never_waits: assert property (@(posedge iclk) disable iff (!rst_n)
    ld_req |-> ld_gnt)  // input has no back-pressure
    else $error("loader request not granted");

  // ------------------------------------------------------------
  // output framing
  // ------------------------------------------------------------

  last_in_frame: assert property (@(posedge iclk) disable iff (!rst_n)
    out_last |-> out_valid)
    else $error("out_last without out_valid");

  valid_while_busy: assert property (@(posedge iclk) disable iff (!rst_n)
    out_valid |-> busy)
    else $error("out_valid while busy is low");

endmodule

// RAM side sees no output stream, ACU side sees no grants
bind ldpc_enc_info_ram ldpc_enc_asserts u_ram_asserts (
  .iclk      (iclk),
  .rst_n     (rst_n),
  .ld_req    (ld_port.req),
  .ld_gnt    (ld_gnt),
  .eng_gnt   (eng_gnt),
  .out_valid (1'b0),
  .out_last  (1'b0),
  .busy      (1'b0)
);

bind ldpc_enc_acu ldpc_enc_asserts u_acu_asserts (
  .iclk      (iclk),
  .rst_n     (rst_n),
  .ld_req    (1'b0),
  .ld_gnt    (1'b0),
  .eng_gnt   (1'b0),
  .out_valid (out_valid),
  .out_last  (out_last),
  .busy      (busy)
);

// ==== tb/ldpc_enc_tb.sv ====
// LDPC encoder parity accumulator testbench
// LFSR frames in, reference parity per frame, in-order compare of the stream

`timescale 1ns/1ns

`include "ldpc_enc_defs.svh"

module ldpc_enc_tb import ldpc_enc_pkg::*; ();

  localparam int FRAME_W   = `LDPC_ZF * `LDPC_NT;   // info bits per frame
  localparam int PAR_W     = `LDPC_ZF * `LDPC_NC;   // parity bits per frame
  localparam int IN_WORDS  = FRAME_W / `LDPC_DAT_W;
  localparam int OUT_WORDS = PAR_W / `LDPC_DAT_W;
  localparam int IDLE_TMO  = 500;                   // cycles to wait for busy low
  localparam int N_B2B     = 20;                    // back-to-back frames

  logic iclk;
  logic rst_n;
  logic in_valid;
  dat_t in_word;
  logic start;
  logic out_valid;
  dat_t out_word;
  logic out_last;
  logic busy;

  logic [31:0] lfsr;
  dat_t        exp_q [$];         // expected parity in stream order
  int          frames_started = 0;
  int          frames_done    = 0;
  int          err_cnt        = 0;

  ldpc_enc_top u_dut (
    .iclk      (iclk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_word   (in_word),
    .start     (start),
    .out_valid (out_valid),
    .out_word  (out_word),
    .out_last  (out_last),
    .busy      (busy)
  );

  initial begin
    iclk = 1'b0;
    forever #5 iclk = ~iclk;  // 10 ns
  end

  // ------------------------------------------------------------
  // reference model and helpers
  // ------------------------------------------------------------

  // p_c bit i = xor over t of u_t bit (i + Hb[c][t]) mod Z
  function automatic logic [PAR_W-1:0] ldpc_ref_parity(input logic [FRAME_W-1:0] frame);
    logic [PAR_W-1:0] par;
    hb_entry_u        e;
    int               s;
    par = '0;
    for (int c = 0; c < `LDPC_NC; c++) begin
      for (int t = 0; t < `LDPC_NT; t++) begin
        e = hb_tab[c][t];
        if (e.raw >= 0) begin  // -1 is an empty block
          s = int'(e.raw);
          for (int i = 0; i < `LDPC_ZF; i++) begin
            par[c*`LDPC_ZF + i] ^= frame[t*`LDPC_ZF + (i + s) % `LDPC_ZF];
          end
        end
      end
    end
    return par;
  endfunction

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic rand_frame(output logic [FRAME_W-1:0] f);
    for (int i = 0; i < FRAME_W; i++) begin
      lfsr = lfsr_step(lfsr);  // one step per bit
      f[i] = lfsr[0];
    end
  endtask

  task automatic fail_run(input string line);
    err_cnt++;
    $display("%s", line);
    $display("TESTS FAILED");
    $fatal(1, "stopping on first error");
  endtask

  task automatic check_word(input dat_t got, input dat_t exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("FAILED at %0t ns: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  // ------------------------------------------------------------
  // stimulus tasks are called and return on a falling edge
  // ------------------------------------------------------------

  task automatic load_frame(input logic [FRAME_W-1:0] frame);
    for (int k = 0; k < IN_WORDS; k++) begin
      in_valid = 1'b1;
      in_word  = frame[k*`LDPC_DAT_W +: `LDPC_DAT_W];  // word 0 first
      @(negedge iclk);
    end
    in_valid = 1'b0;
    in_word  = '0;
  endtask

  task automatic start_encode(input logic [FRAME_W-1:0] frame);
    logic [PAR_W-1:0] par;
    par = ldpc_ref_parity(frame);
    for (int k = 0; k < OUT_WORDS; k++) begin
      exp_q.push_back(par[k*`LDPC_DAT_W +: `LDPC_DAT_W]);
    end
    frames_started++;
    start = 1'b1;
    @(negedge iclk);
    start = 1'b0;
    check_flag(busy, 1'b1, "busy after start");
  endtask

  task automatic wait_idle();
    int cyc;
    cyc = 0;
    while (busy) begin
      @(negedge iclk);
      cyc++;
      if (cyc > IDLE_TMO) begin
        fail_run($sformatf("timeout at %0t ns: busy still high after %0d cycles",
                           $time, IDLE_TMO));
      end
    end
    @(negedge iclk);
    check_flag(out_valid, 1'b0, "out_valid after frame");
    check_flag(busy, 1'b0, "busy after frame");
    if (exp_q.size() != 0 || frames_done != frames_started) begin
      fail_run($sformatf("frame ended at %0t ns with %0d parity words never sent",
                         $time, exp_q.size()));
    end
  endtask

  task automatic run_frame(input logic [FRAME_W-1:0] frame);
    load_frame(frame);
    start_encode(frame);
    wait_idle();
  endtask

  // ------------------------------------------------------------
  // compare process
  // ------------------------------------------------------------

  initial begin : compare_stream
    int   word_cnt;
    dat_t exp_w;
    word_cnt = 0;
    forever begin
      @(negedge iclk);  // registered outputs are stable mid-cycle
      if (out_valid) begin
        if (exp_q.size() == 0) begin
          fail_run($sformatf("parity word at %0t ns with no frame started", $time));
        end
        exp_w = exp_q.pop_front();
        check_word(out_word, exp_w, $sformatf("parity word %0d", word_cnt));
        check_flag(out_last, word_cnt == OUT_WORDS - 1, "out_last");
        if (word_cnt == OUT_WORDS - 1) begin
          word_cnt = 0;
          frames_done++;
        end else begin
          word_cnt++;
        end
      end else begin
        check_flag(out_last, 1'b0, "out_last outside frame");
      end
    end
  end

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------

  initial begin : main_seq
    logic [FRAME_W-1:0] cur;
    logic [FRAME_W-1:0] nxt;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_word  = '0;
    start    = 1'b0;
    lfsr     = 32'h14eb_e289;
    repeat (16) @(negedge iclk);
    rst_n = 1'b1;
    @(negedge iclk);
    check_flag(out_valid, 1'b0, "out_valid after reset");
    check_flag(out_last, 1'b0, "out_last after reset");
    check_flag(busy, 1'b0, "busy after reset");

    rand_frame(cur);  // single random frame
    run_frame(cur);

    run_frame('0);                      // edge frames
    run_frame(FRAME_W'(1) << 37);
    run_frame('1);

    // next frame streams in while the current one encodes
    rand_frame(cur);
    load_frame(cur);
    for (int n = 0; n < N_B2B; n++) begin
      rand_frame(nxt);
      start_encode(cur);
      repeat (n) @(negedge iclk);  // engine gets n reads in before the stall
      load_frame(nxt);             // loader wins every slot it asks for
      wait_idle();
      cur = nxt;
    end
    start_encode(cur);
    wait_idle();

    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
